//--- run.sh
#!/bin/sh
# build with verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -f tb.f --top-module csr_tb -o csr_tb &&
    ./obj_dir/csr_tb | tee /dev/stderr | grep -q '^>>> PASS$' &&
    echo "simulation passed" ||
    { echo "simulation failed"; exit 1; }

//--- sim/csr_tb.sv
`default_nettype none

module csr_tb;
    import csr_pkg::*;

    localparam word_t hart = 64'd3;
    localparam int max_cycles = 600;

    logic     clk;
    logic     rst;
    logic     inst_valid;
    csr_idx_t csr_index;
    csr_op_t  csr_op;
    logic     csr_src;
    word_t    rs1_data;
    word_t    csr_imm;
    word_t    inst_addr;
    logic     inst_ecall;
    logic     inst_ebreak;
    logic     inst_mret;
    logic     timer_wr_en;
    logic     timer_wr_sel;
    word_t    timer_wdata;
    word_t    csr_rdata;
    logic     redirect;
    word_t    redirect_pc;

    // reference model state
    word_t m_status;
    word_t m_mie;
    word_t m_tvec;
    word_t m_scratch;
    word_t m_epc;
    word_t m_cause;
    word_t m_instret;

    word_t       exp_rdata;
    word_t       exp_pc;
    word_t       prev_rdata;
    logic        exp_redir;
    logic        chk_rd;
    logic        chk_redir;
    logic        cyc_pair;
    logic [31:0] lfsr;
    int          errors;
    int          cycles;

    csr_unit_top #(.tick_div(2), .hart_id(hart)) csr_unit_top_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // previous cycle's read for the mcycle step
    always @(posedge clk) prev_rdata <= csr_rdata;

    a_rdata: assert property (@(posedge clk) disable iff (rst)
        chk_rd |-> csr_rdata == exp_rdata)
        else begin
            errors++;
            $display("error at %0t: csr_rdata = %h, expected %h",
                     $time, $sampled(csr_rdata), $sampled(exp_rdata));
        end

    a_redir: assert property (@(posedge clk) disable iff (rst)
        chk_redir |-> redirect == exp_redir)
        else begin
            errors++;
            $display("error at %0t: redirect = %b, expected %b",
                     $time, $sampled(redirect), $sampled(exp_redir));
        end

    a_pc: assert property (@(posedge clk) disable iff (rst)
        redirect |-> redirect_pc == exp_pc)
        else begin
            errors++;
            $display("error at %0t: redirect_pc = %h, expected %h",
                     $time, $sampled(redirect_pc), $sampled(exp_pc));
        end

    a_mcycle: assert property (@(posedge clk) disable iff (rst)
        cyc_pair |-> csr_rdata == prev_rdata + 64'd1)
        else begin
            errors++;
            $display("error at %0t: csr_rdata = %h, expected %h", $time,
                     $sampled(csr_rdata), $sampled(prev_rdata) + 64'd1);
        end

    // fibonacci lfsr with taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_word(output word_t w, input int nbits);
        w = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[62:0], lfsr[0]};
        end
    endtask

    function automatic word_t model_read(input csr_idx_t idx);
        case (idx)
            csr_mstatus:  return m_status;
            csr_misa:     return 64'h8000_0000_0000_0100;
            csr_mie:      return m_mie;
            csr_mtvec:    return m_tvec;
            csr_mscratch: return m_scratch;
            csr_mepc:     return m_epc;
            csr_mcause:   return m_cause;
            csr_minstret: return m_instret;
            csr_marchid:  return 64'd1;
            csr_mhartid:  return hart;
            default:      return '0;
        endcase
    endfunction

    task automatic model_write(input csr_idx_t idx, input word_t v);
        case (idx)
            csr_mstatus:  m_status = v;
            csr_mie:      m_mie = v & 64'h80;
            csr_mtvec:    m_tvec = v & ~64'h3;
            csr_mscratch: m_scratch = v;
            csr_mepc:     m_epc = v;
            csr_mcause:   m_cause = v;
            csr_minstret: m_instret = v;
            default: ;
        endcase
    endtask

    task automatic model_enter(input word_t addr, input word_t cause);
        m_epc = addr;
        m_cause = cause;
        m_status[7] = m_status[3];
        m_status[3] = 1'b0;
        m_status[12:11] = 2'b11;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #10;
        inst_valid = 1'b0;
        inst_ecall = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret = 1'b0;
        csr_op = csr_none;
        timer_wr_en = 1'b0;
        chk_rd = 1'b0;
        exp_redir = 1'b0;
        cyc_pair = 1'b0;
    endtask

    task automatic drive_csr(input csr_idx_t idx, input csr_op_t op, input logic src,
                             input word_t rs1, input word_t imm);
        inst_valid = 1'b1;
        csr_index = idx;
        csr_op = op;
        csr_src = src;
        rs1_data = rs1;
        csr_imm = imm;
        exp_rdata = model_read(idx);
        chk_rd = (idx != csr_mcycle);
        exp_pc = m_tvec;
    endtask

    task automatic csr_inst(input csr_idx_t idx, input csr_op_t op, input logic src,
                            input word_t rs1, input word_t imm);
        word_t old;
        word_t operand;
        old = model_read(idx);
        operand = src ? imm : rs1;
        drive_csr(idx, op, src, rs1, imm);
        m_instret = m_instret + 64'd1;
        case (op)
            csr_write: model_write(idx, operand);
            csr_set:   model_write(idx, old | operand);
            csr_clear: model_write(idx, old & ~operand);
            default: ;
        endcase
        next_cycle();
    endtask

    task automatic read_csr(input csr_idx_t idx);
        csr_inst(idx, csr_set, 1'b0, '0, '0);
    endtask

    task automatic trap_inst(input logic ecall, input logic ebreak, input word_t addr);
        inst_valid = 1'b1;
        inst_ecall = ecall;
        inst_ebreak = ebreak;
        inst_mret = !(ecall || ebreak);
        inst_addr = addr;
        exp_redir = 1'b1;
        if (ecall || ebreak) begin
            exp_pc = m_tvec;
            model_enter(addr, ecall ? 64'd11 : 64'd3);
        end else begin
            // mret
            exp_pc = m_epc;
            m_status[3] = m_status[7];
            m_status[7] = 1'b1;
            m_status[12:11] = 2'b00;
            m_instret = m_instret + 64'd1;
        end
        next_cycle();
    endtask

    task automatic timer_write(input logic sel, input word_t data);
        timer_wr_en = 1'b1;
        timer_wr_sel = sel;
        timer_wdata = data;
        next_cycle();
    endtask

    initial begin
        int      n;
        logic    taken;
        word_t   r;
        word_t   v;
        word_t   imm;
        csr_op_t op;
        rst = 1'b1;
        inst_valid = 1'b0;
        csr_index = '0;
        csr_op = csr_none;
        csr_src = 1'b0;
        rs1_data = '0;
        csr_imm = '0;
        inst_addr = '0;
        inst_ecall = 1'b0;
        inst_ebreak = 1'b0;
        inst_mret = 1'b0;
        timer_wr_en = 1'b0;
        timer_wr_sel = 1'b0;
        timer_wdata = '0;
        {m_status, m_mie, m_tvec, m_scratch} = '0;
        {m_epc, m_cause, m_instret} = '0;
        {exp_rdata, exp_pc} = '0;
        {exp_redir, chk_rd, cyc_pair} = '0;
        chk_redir = 1'b1;
        lfsr = 32'h6c77_1229;
        errors = 0;
        repeat (3) @(posedge clk);
        #10;
        rst = 1'b0;

        read_csr(csr_misa);
        read_csr(csr_marchid);
        read_csr(csr_mhartid);
        read_csr(csr_mscratch);
        read_csr(csr_mtvec);
        read_csr(csr_mcause);

        // random csr traffic on mscratch
        for (n = 0; n < 40; n++) begin
            rand_word(r, 2);
            case (r[1:0])
                2'd1:    op = csr_set;
                2'd2:    op = csr_clear;
                default: op = csr_write;
            endcase
            rand_word(v, 64);
            rand_word(imm, 5);
            rand_word(r, 1);
            csr_inst(csr_mscratch, op, r[0], v, imm);
        end
        read_csr(csr_mscratch);

        csr_inst(csr_mtvec, csr_write, 1'b0, '1, '0);
        read_csr(csr_mtvec);
        csr_inst(csr_mie, csr_write, 1'b0, '1, '0);
        read_csr(csr_mie);
        csr_inst(csr_mtvec, csr_write, 1'b0, 64'h8000_0100, '0);

        // ecall and ebreak with mie set beforehand
        csr_inst(csr_mstatus, csr_set, 1'b1, '0, 64'h8);
        trap_inst(1'b1, 1'b0, 64'h8000_0040);
        read_csr(csr_mepc);
        read_csr(csr_mcause);
        read_csr(csr_mstatus);
        trap_inst(1'b0, 1'b0, 64'h8000_0104);
        read_csr(csr_mstatus);
        trap_inst(1'b0, 1'b1, 64'h8000_0048);
        read_csr(csr_mepc);
        read_csr(csr_mcause);
        read_csr(csr_mstatus);
        trap_inst(1'b0, 1'b0, 64'h8000_0108);
        read_csr(csr_mstatus);

        // timer interrupt with mie bit 7 and mstatus mie already set
        timer_write(1'b1, 64'd100);
        timer_write(1'b0, 64'd104);
        taken = 1'b0;
        chk_redir = 1'b0;
        for (n = 0; n < 20 && !taken; n++) begin
            rand_word(v, 64);
            inst_addr = 64'h8000_0200 + 64'(n * 4);
            drive_csr(csr_mscratch, csr_write, 1'b0, v, '0);
            #1;
            if (redirect) begin
                taken = 1'b1;
                model_enter(inst_addr, 64'h8000_0000_0000_0007);
            end else begin
                m_scratch = v;
                m_instret = m_instret + 64'd1;
            end
            next_cycle();
        end
        chk_redir = 1'b1;
        if (!taken) begin
            errors++;
            $display("timer interrupt was not taken within 20 cycles");
        end
        read_csr(csr_mcause);
        read_csr(csr_mscratch);
        read_csr(csr_mstatus);

        // counters
        read_csr(csr_minstret);
        next_cycle();
        next_cycle();
        read_csr(csr_minstret);
        // no csr op so mcycle keeps counting
        csr_inst(csr_mcycle, csr_none, 1'b0, '0, '0);
        cyc_pair = 1'b1;
        csr_inst(csr_mcycle, csr_none, 1'b0, '0, '0);

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("run did not finish within %0d cycles, errors: %0d", max_cycles, errors);
        $display(">>> FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/clint_timer.sv
`default_nettype none

module clint_timer #(
    parameter int unsigned tick_div = 2
) (
    input  wire logic           clk,
    input  wire logic           rst,
    input  wire logic           timer_wr_en,
    input  wire logic           timer_wr_sel,
    input  wire csr_pkg::word_t timer_wdata,
    output logic                mtip
);
    import csr_pkg::*;

    localparam int unsigned cnt_w = (tick_div > 1) ? $clog2(tick_div) : 1;

    logic [cnt_w-1:0] presc;
    logic             tick;
    word_t            mtime;
    word_t            mtimecmp;
    word_t            mtime_nxt;
    word_t            mtimecmp_nxt;

    assign tick = (presc == cnt_w'(tick_div - 1));

    // mtime write wins over the tick
    always_comb begin
        mtime_nxt    = mtime;
        mtimecmp_nxt = mtimecmp;
        if (timer_wr_en && timer_wr_sel) begin
            mtime_nxt = timer_wdata;
        end else if (tick) begin
            mtime_nxt = mtime + word_t'(1);
        end
        if (timer_wr_en && !timer_wr_sel) begin
            mtimecmp_nxt = timer_wdata;
        end
    end

    // compare on next values so mtip rises with mtime
    always_ff @(posedge clk) begin
        if (rst) begin
            presc    <= '0;
            mtime    <= '0;
            mtimecmp <= '1;
            mtip     <= 1'b0;
        end else begin
            presc    <= tick ? '0 : presc + cnt_w'(1);
            mtime    <= mtime_nxt;
            mtimecmp <= mtimecmp_nxt;
            mtip     <= (mtime_nxt >= mtimecmp_nxt);
        end
    end

endmodule

`default_nettype wire

//--- source/csr_file.sv
`default_nettype none

module csr_file #(
    parameter csr_pkg::word_t hart_id = '0
) (
    input  wire logic             clk,
    input  wire logic             rst,
    input  wire logic             inst_valid,
    input  wire csr_pkg::csr_idx_t csr_index,
    input  wire csr_pkg::csr_op_t csr_op,
    input  wire logic             csr_src,
    input  wire csr_pkg::word_t   rs1_data,
    input  wire csr_pkg::word_t   csr_imm,
    input  wire logic             mtip,
    output csr_pkg::word_t        csr_rdata,
    trap_if.regs                  trap
);
    import csr_pkg::*;

    word_t mstatus_r;
    word_t mtvec_r;
    word_t mepc_r;
    word_t mcause_r;
    word_t mie_r;
    word_t mscratch_r;
    word_t mcycle_r;
    word_t minstret_r;
    word_t mip_val;

    word_t operand;
    word_t new_value;
    logic  wr_en;

    // timer pending is live, not stored
    assign mip_val = word_t'(mtip) << 7;

    assign operand = csr_src ? csr_imm : rs1_data;

    // trap entry suppresses the instruction's own write
    assign wr_en = inst_valid && (csr_op != csr_none) && !trap.enter;

    // old value is also the base for set and clear
    always_comb begin
        case (csr_index)
            csr_mstatus:   csr_rdata = mstatus_r;
            csr_misa:      csr_rdata = misa_value;
            csr_mie:       csr_rdata = mie_r;
            csr_mtvec:     csr_rdata = mtvec_r;
            csr_mscratch:  csr_rdata = mscratch_r;
            csr_mepc:      csr_rdata = mepc_r;
            csr_mcause:    csr_rdata = mcause_r;
            csr_mip:       csr_rdata = mip_val;
            csr_mcycle:    csr_rdata = mcycle_r;
            csr_minstret:  csr_rdata = minstret_r;
            csr_mvendorid: csr_rdata = '0;
            csr_marchid:   csr_rdata = marchid_value;
            csr_mimpid:    csr_rdata = '0;
            csr_mhartid:   csr_rdata = hart_id;
            default:       csr_rdata = '0;
        endcase
    end

    always_comb begin
        case (csr_op)
            csr_write: new_value = operand;
            csr_set:   new_value = csr_rdata | operand;
            csr_clear: new_value = csr_rdata & ~operand;
            default:   new_value = csr_rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r <= '0;
        end else if (wr_en && csr_index == csr_mstatus) begin
            mstatus_r <= new_value;
        end else if (trap.enter) begin
            mstatus_r[mstatus_mpie] <= mstatus_r[mstatus_mie];
            mstatus_r[mstatus_mie] <= 1'b0;
            mstatus_r[mstatus_mpp_hi:mstatus_mpp_lo] <= 2'b11;
        end else if (trap.leave) begin
            mstatus_r[mstatus_mie] <= mstatus_r[mstatus_mpie];
            mstatus_r[mstatus_mpie] <= 1'b1;
            mstatus_r[mstatus_mpp_hi:mstatus_mpp_lo] <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r   <= '0;
            mcause_r <= '0;
        end else if (trap.enter) begin
            mepc_r   <= trap.epc;
            mcause_r <= trap.cause;
        end else if (wr_en) begin
            if (csr_index == csr_mepc) begin
                mepc_r <= new_value;
            end
            if (csr_index == csr_mcause) begin
                mcause_r <= new_value;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_r    <= '0;
            mie_r      <= '0;
            mscratch_r <= '0;
        end else if (wr_en) begin
            case (csr_index)
                // direct mode only
                csr_mtvec:    mtvec_r <= new_value & ~word_t'(3);
                csr_mie:      mie_r <= new_value & mie_mask;
                csr_mscratch: mscratch_r <= new_value;
                default: ;
            endcase
        end
    end

    // explicit counter write wins over the increment
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_r <= '0;
        end else if (wr_en && csr_index == csr_mcycle) begin
            mcycle_r <= new_value;
        end else begin
            mcycle_r <= mcycle_r + word_t'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_r <= '0;
        end else if (wr_en && csr_index == csr_minstret) begin
            minstret_r <= new_value;
        end else if (inst_valid && !trap.enter) begin
            minstret_r <= minstret_r + word_t'(1);
        end
    end

    assign trap.mtvec = mtvec_r;
    assign trap.mepc  = mepc_r;
    assign trap.irq_ready = mstatus_r[mstatus_mie] & mie_r[7] & mip_val[7];

endmodule

`default_nettype wire

//--- source/csr_pkg.sv
`default_nettype none

package csr_pkg;

    parameter int xlen = 64;

    typedef logic [11:0] csr_idx_t;
    typedef logic [xlen-1:0] word_t;

    typedef enum logic [1:0] {
        csr_none,
        csr_write,
        csr_set,
        csr_clear
    } csr_op_t;

    // machine-mode csr indices
    localparam csr_idx_t csr_mstatus   = 12'h300;
    localparam csr_idx_t csr_misa      = 12'h301;
    localparam csr_idx_t csr_mie       = 12'h304;
    localparam csr_idx_t csr_mtvec     = 12'h305;
    localparam csr_idx_t csr_mscratch  = 12'h340;
    localparam csr_idx_t csr_mepc      = 12'h341;
    localparam csr_idx_t csr_mcause    = 12'h342;
    localparam csr_idx_t csr_mip       = 12'h344;
    localparam csr_idx_t csr_mcycle    = 12'hB00;
    localparam csr_idx_t csr_minstret  = 12'hB02;
    localparam csr_idx_t csr_mvendorid = 12'hF11;
    localparam csr_idx_t csr_marchid   = 12'hF12;
    localparam csr_idx_t csr_mimpid    = 12'hF13;
    localparam csr_idx_t csr_mhartid   = 12'hF14;

    localparam word_t cause_ecall  = word_t'(11);
    localparam word_t cause_ebreak = word_t'(3);
    // interrupt flag in the top bit
    localparam word_t cause_mtimer = {1'b1, {(xlen - 4){1'b0}}, 3'd7};

    // rv64i with mxl = 2
    localparam word_t misa_value    = {2'b10, {(xlen - 28){1'b0}}, 26'h100};
    localparam word_t marchid_value = word_t'(1);
    localparam word_t mie_mask      = word_t'(64'h80);

    localparam int mstatus_mie    = 3;
    localparam int mstatus_mpie   = 7;
    localparam int mstatus_mpp_lo = 11;
    localparam int mstatus_mpp_hi = 12;

endpackage

`default_nettype wire

//--- source/csr_unit_top.sv
`default_nettype none

module csr_unit_top #(
    parameter int unsigned    tick_div = 2,
    parameter csr_pkg::word_t hart_id  = '0
) (
    input  wire logic              clk,
    input  wire logic              rst,
    input  wire logic              inst_valid,
    input  wire csr_pkg::csr_idx_t csr_index,
    input  wire csr_pkg::csr_op_t  csr_op,
    input  wire logic              csr_src,
    input  wire csr_pkg::word_t    rs1_data,
    input  wire csr_pkg::word_t    csr_imm,
    input  wire csr_pkg::word_t    inst_addr,
    input  wire logic              inst_ecall,
    input  wire logic              inst_ebreak,
    input  wire logic              inst_mret,
    input  wire logic              timer_wr_en,
    input  wire logic              timer_wr_sel,
    input  wire csr_pkg::word_t    timer_wdata,
    output csr_pkg::word_t         csr_rdata,
    output logic                   redirect,
    output csr_pkg::word_t         redirect_pc
);

    logic mtip;

    trap_if trap_bus ();

    csr_file #(
        .hart_id (hart_id)
    ) csr_file_i (
        .clk        (clk),
        .rst        (rst),
        .inst_valid (inst_valid),
        .csr_index  (csr_index),
        .csr_op     (csr_op),
        .csr_src    (csr_src),
        .rs1_data   (rs1_data),
        .csr_imm    (csr_imm),
        .mtip       (mtip),
        .csr_rdata  (csr_rdata),
        .trap       (trap_bus)
    );

    trap_ctrl trap_ctrl_i (
        .inst_valid  (inst_valid),
        .inst_ecall  (inst_ecall),
        .inst_ebreak (inst_ebreak),
        .inst_mret   (inst_mret),
        .inst_addr   (inst_addr),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .trap        (trap_bus)
    );

    clint_timer #(
        .tick_div (tick_div)
    ) clint_timer_i (
        .clk          (clk),
        .rst          (rst),
        .timer_wr_en  (timer_wr_en),
        .timer_wr_sel (timer_wr_sel),
        .timer_wdata  (timer_wdata),
        .mtip         (mtip)
    );

endmodule

`default_nettype wire

//--- source/trap_ctrl.sv
`default_nettype none

module trap_ctrl (
    input  wire logic           inst_valid,
    input  wire logic           inst_ecall,
    input  wire logic           inst_ebreak,
    input  wire logic           inst_mret,
    input  wire csr_pkg::word_t inst_addr,
    output logic                redirect,
    output csr_pkg::word_t      redirect_pc,
    trap_if.ctrl                trap
);
    import csr_pkg::*;

    // faulting pc is always the current instruction
    assign trap.epc = inst_addr;

    // interrupt first, then ecall, ebreak, mret
    always_comb begin
        trap.enter  = 1'b0;
        trap.leave  = 1'b0;
        trap.cause  = '0;
        redirect    = 1'b0;
        redirect_pc = '0;
        if (inst_valid) begin
            if (trap.irq_ready) begin
                trap.enter  = 1'b1;
                trap.cause  = cause_mtimer;
                redirect    = 1'b1;
                redirect_pc = trap.mtvec;
            end else if (inst_ecall) begin
                trap.enter  = 1'b1;
                trap.cause  = cause_ecall;
                redirect    = 1'b1;
                redirect_pc = trap.mtvec;
            end else if (inst_ebreak) begin
                trap.enter  = 1'b1;
                trap.cause  = cause_ebreak;
                redirect    = 1'b1;
                redirect_pc = trap.mtvec;
            end else if (inst_mret) begin
                trap.leave  = 1'b1;
                redirect    = 1'b1;
                redirect_pc = trap.mepc;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/trap_if.sv
`default_nettype none

interface trap_if;
    import csr_pkg::*;

    // trap control to csr file
    logic  enter;
    logic  leave;
    word_t cause;
    word_t epc;

    // csr file to trap control
    word_t mtvec;
    word_t mepc;
    logic  irq_ready;

    modport ctrl (
        output enter, leave, cause, epc,
        input  mtvec, mepc, irq_ready
    );

    modport regs (
        input  enter, leave, cause, epc,
        output mtvec, mepc, irq_ready
    );

endinterface

`default_nettype wire

//--- tb.f
source/csr_pkg.sv
source/trap_if.sv
source/csr_file.sv
source/trap_ctrl.sv
source/clint_timer.sv
source/csr_unit_top.sv
sim/csr_tb.sv
